/* fmul_unit.f */
+incdir+testbench
verilog/fmul_fp_pkg.sv
verilog/fmul_bus_pkg.sv
verilog/fmul_mantissa_tree.sv
verilog/fmul_exponent.sv
verilog/fmul_round_pack.sv
verilog/fmul_core.sv
verilog/fmul_apb_regs.sv
verilog/fmul_unit.sv
testbench/fmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module fmul_tb \
    -f fmul_unit.f -o fmul_sim &&
  ./obj_dir/fmul_sim | tee sim.log &&
  grep -qF '*** TEST PASSED ***' sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* testbench/fmul_ref.svh */
`ifndef FMUL_REF_SVH
`define FMUL_REF_SVH

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// binary64 multiply model, flush-to-zero, rounded from the exact product
task automatic ref_mul(
  input  logic [63:0] a,
  input  logic [63:0] b,
  input  round_mode_t mode,
  output logic [63:0] res,
  output logic [3:0]  flg
);
  logic [10:0]  ea;
  logic [10:0]  eb;
  logic [51:0]  fa;
  logic [51:0]  fb;
  logic         s;
  logic         nan_a;
  logic         nan_b;
  logic         inf_a;
  logic         inf_b;
  logic         zero_a;
  logic         zero_b;
  logic         inf_zero;
  logic [105:0] p;
  logic [53:0]  m;
  logic         rb;
  logic         st;
  logic         up;
  int           e;
  ea = a[62:52];
  eb = b[62:52];
  fa = a[51:0];
  fb = b[51:0];
  s = a[63] ^ b[63];
  flg = 4'h0;
  nan_a = (ea == 11'h7ff) && (fa != 52'h0);
  nan_b = (eb == 11'h7ff) && (fb != 52'h0);
  inf_a = (ea == 11'h7ff) && (fa == 52'h0);
  inf_b = (eb == 11'h7ff) && (fb == 52'h0);
  zero_a = (ea == 11'h0);
  zero_b = (eb == 11'h0);
  inf_zero = (inf_a && zero_b) || (inf_b && zero_a);
  if (nan_a || nan_b || inf_zero) begin
    res = 64'h7ff8_0000_0000_0000;
    flg[flag_invalid] = inf_zero || (nan_a && !fa[51]) || (nan_b && !fb[51]);
  end else if (inf_a || inf_b) begin
    res = {s, 11'h7ff, 52'h0};
  end else if (zero_a || zero_b) begin
    res = {s, 63'h0};
  end else begin
    p = 106'({1'b1, fa}) * 106'({1'b1, fb});
    e = int'(ea) + int'(eb) - 1023;
    if (p[105]) begin
      e = e + 1;
    end else begin
      p = p << 1;
    end
    m = {1'b0, p[105:53]};
    rb = p[52];
    st = |p[51:0];
    case (mode)
      rnd_even: up = rb && (st || m[0]);
      rnd_zero: up = 1'b0;
      rnd_plus: up = (rb || st) && !s;
      default:  up = (rb || st) && s;
    endcase
    m = m + 54'(up);
    if (m[53]) begin
      e = e + 1;
      m = m >> 1;
    end
    flg[flag_inexact] = rb || st;
    if (e >= 2047) begin
      if (mode == rnd_zero || (mode == rnd_plus && s) || (mode == rnd_minus && !s)) begin
        res = {s, 63'h7fef_ffff_ffff_ffff};
      end else begin
        res = {s, 11'h7ff, 52'h0};
      end
      flg[flag_overflow] = 1'b1;
      flg[flag_inexact] = 1'b1;
    end else if (e < 1) begin
      res = {s, 63'h0};
      flg[flag_underflow] = 1'b1;
      flg[flag_inexact] = 1'b1;
    end else begin
      res = {s, e[10:0], m[51:0]};
    end
  end
endtask

`endif

/* testbench/fmul_tb.sv */
module fmul_tb import fmul_fp_pkg::*; import fmul_bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xfer_limit = 50;
  localparam int settle_ns  = 5;
  localparam logic [3:0] inv_flags = 4'(1 << flag_invalid);
  localparam logic [3:0] ovf_flags = 4'((1 << flag_overflow) | (1 << flag_inexact));
  localparam logic [3:0] unf_flags = 4'((1 << flag_underflow) | (1 << flag_inexact));
  localparam logic [63:0] big_a   = 64'h7e78_0000_0000_0000;
  localparam logic [63:0] big_b   = 64'h4638_0000_0000_0000;
  localparam logic [63:0] tiny_a  = 64'h1a70_0000_0000_0000;
  localparam logic [63:0] tiny_b  = 64'h9a70_0000_0000_0000;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          check_errors;
  int          bus_errors;
  int          start_count;
  logic [31:0] lcg_state;

  `include "fmul_ref.svh"

  fmul_unit u_fmul_unit (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      check_errors++;
    end
  endtask

  // setup then access phase with outputs sampled mid-cycle
  task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int waits, output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    #(settle_ns);
    while (!pready && waits < xfer_limit) begin
      @(negedge clk);
      #(settle_ns);
      waits++;
    end
    if (!pready) begin
      $display("transfer to address %h timed out waiting for pready", addr);
      bus_errors++;
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          waits;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, waits, err);
    if (err) begin
      $display("unexpected slave error on write to address %h", addr);
      bus_errors++;
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output int waits);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, waits, err);
    if (err) begin
      $display("unexpected slave error on read from address %h", addr);
      bus_errors++;
    end
  endtask

  function automatic logic [31:0] start_word(input round_mode_t mode);
    return (32'd1 << ctrl_start) | 32'(mode);
  endfunction

  task automatic issue_start(input round_mode_t mode);
    apb_write(addr_ctrl, start_word(mode));
    start_count++;
  endtask

  task automatic write_operands(input logic [63:0] a, input logic [63:0] b);
    apb_write(addr_a_lo, a[31:0]);
    apb_write(addr_a_hi, a[63:32]);
    apb_write(addr_b_lo, b[31:0]);
    apb_write(addr_b_hi, b[63:32]);
  endtask

  // random normal operand with its exponent near mid-range
  task automatic next_operand(output logic [63:0] v);
    lcg_state = lcg_next(lcg_state);
    v[31:0] = lcg_state;
    lcg_state = lcg_next(lcg_state);
    v[51:32] = lcg_state[19:0];
    v[62:52] = 11'd767 + 11'(lcg_state[28:20]);
    v[63] = lcg_state[31];
  endtask

  task automatic run_case(input string name, input logic [63:0] a, input logic [63:0] b,
                          input round_mode_t mode, input logic [63:0] exp_res,
                          input logic [3:0] exp_flags);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] fl;
    int          waits;
    apb_write(addr_flags, 32'hf);
    write_operands(a, b);
    issue_start(mode);
    apb_read(addr_res_lo, lo, waits);
    apb_read(addr_res_hi, hi, waits);
    apb_read(addr_flags, fl, waits);
    check_value($sformatf("%s %s result", name, mode.name()), exp_res, {hi, lo});
    check_value($sformatf("%s %s flags", name, mode.name()), 64'(exp_flags), 64'(fl[3:0]));
  endtask

  task automatic model_case(input string name, input logic [63:0] a, input logic [63:0] b,
                            input round_mode_t mode);
    logic [63:0] exp_res;
    logic [3:0]  exp_flags;
    ref_mul(a, b, mode, exp_res, exp_flags);
    run_case(name, a, b, mode, exp_res, exp_flags);
  endtask

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_res;
    logic [3:0]  exp_flags;
    logic [3:0]  or_flags;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] status1;
    logic [31:0] fl0;
    logic [31:0] fl1;
    logic [31:0] alo0;
    logic [31:0] alo1;
    logic [31:0] rd;
    logic [7:0]  done_exp;
    int          waits;
    logic        err;
    clk = 1'b0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 8'h0;
    pwdata = 32'h0;
    check_errors = 0;
    bus_errors = 0;
    start_count = 0;
    lcg_state = 32'h12d1_c165;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (int m = 0; m < 4; m++) begin
      run_case("exact 1.5*2.0", 64'h3ff8_0000_0000_0000, 64'h4000_0000_0000_0000,
               round_mode_t'(m), 64'h4008_0000_0000_0000, 4'h0);
      run_case("exact -3.0*0.25", 64'hc008_0000_0000_0000, 64'h3fd0_0000_0000_0000,
               round_mode_t'(m), 64'hbfe8_0000_0000_0000, 4'h0);
    end

    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 200; i++) begin
        next_operand(a);
        next_operand(b);
        model_case("random", a, b, round_mode_t'(m));
      end
    end

    run_case("zero times finite", 64'h8000_0000_0000_0000, 64'h4014_0000_0000_0000,
             rnd_even, 64'h8000_0000_0000_0000, 4'h0);
    run_case("subnormal times finite", 64'h0000_0000_0000_0001, 64'h4000_0000_0000_0000,
             rnd_even, 64'h0, 4'h0);
    run_case("inf times finite", 64'h7ff0_0000_0000_0000, 64'hc000_0000_0000_0000,
             rnd_even, 64'hfff0_0000_0000_0000, 4'h0);
    run_case("inf times zero", 64'h7ff0_0000_0000_0000, 64'h0,
             rnd_even, 64'h7ff8_0000_0000_0000, inv_flags);
    run_case("signaling nan", 64'h7ff0_0000_0000_0001, 64'h3ff0_0000_0000_0000,
             rnd_even, 64'h7ff8_0000_0000_0000, inv_flags);
    run_case("quiet nan", 64'h7ff8_0000_0000_0001, 64'h3ff0_0000_0000_0000,
             rnd_even, 64'h7ff8_0000_0000_0000, 4'h0);

    // max finite when the mode rounds the magnitude down
    for (int m = 0; m < 4; m++) begin
      exp_res = (m == rnd_zero || m == rnd_minus) ? 64'h7fef_ffff_ffff_ffff
                                                  : 64'h7ff0_0000_0000_0000;
      run_case("overflow pos", big_a, big_b, round_mode_t'(m), exp_res, ovf_flags);
      exp_res = (m == rnd_zero || m == rnd_plus) ? 64'hffef_ffff_ffff_ffff
                                                 : 64'hfff0_0000_0000_0000;
      run_case("overflow neg", big_a, {1'b1, big_b[62:0]}, round_mode_t'(m), exp_res,
               ovf_flags);
      run_case("underflow", tiny_a, tiny_b, round_mode_t'(m), 64'h8000_0000_0000_0000,
               unf_flags);
    end

    // four starts in a row and one stalled result read
    apb_write(addr_flags, 32'hf);
    or_flags = 4'h0;
    for (int i = 0; i < 4; i++) begin
      next_operand(a);
      next_operand(b);
      if (i == 1) begin
        a = big_a;
        b = big_b;
      end else if (i == 2) begin
        a = tiny_a;
        b = tiny_b;
      end
      ref_mul(a, b, round_mode_t'(i), exp_res, exp_flags);
      or_flags = or_flags | exp_flags;
      write_operands(a, b);
      issue_start(round_mode_t'(i));
    end
    apb_read(addr_res_lo, lo, waits);
    assert (waits > 0) else begin
      $display("result read right after the burst did not stall");
      check_errors++;
    end
    apb_read(addr_res_hi, hi, waits);
    check_value("burst last result", exp_res, {hi, lo});
    apb_read(addr_status, status1, waits);
    // done count wraps at 8 bits and busy has dropped
    done_exp = 8'(start_count);
    check_value("burst status", 64'({16'h0, done_exp, 8'h00}), 64'(status1));
    apb_read(addr_flags, rd, waits);
    check_value("burst sticky flags", 64'(or_flags), 64'(rd[3:0]));

    // unmapped address
    apb_read(addr_a_lo, alo0, waits);
    apb_read(addr_flags, fl0, waits);
    apb_xfer(1'b1, 8'h24, 32'hffff_ffff, rd, waits, err);
    assert (err) else begin
      $display("write to unmapped address 0x24 completed without a slave error");
      check_errors++;
    end
    apb_xfer(1'b0, 8'h24, 32'h0, rd, waits, err);
    assert (err) else begin
      $display("read from unmapped address 0x24 completed without a slave error");
      check_errors++;
    end
    apb_read(addr_a_lo, alo1, waits);
    apb_read(addr_flags, fl1, waits);
    apb_read(addr_status, rd, waits);
    check_value("unmapped a_lo", 64'(alo0), 64'(alo1));
    check_value("unmapped flags", 64'(fl0), 64'(fl1));
    check_value("unmapped status", 64'(status1), 64'(rd));

    $display("errors: %0d check, %0d bus", check_errors, bus_errors);
    if (check_errors == 0 && bus_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/fmul_apb_regs.sv */
module fmul_apb_regs import fmul_fp_pkg::*; import fmul_bus_pkg::*; #(
  parameter int op_w = 64
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [addr_w-1:0]     paddr,
  input  logic [bus_data_w-1:0] pwdata,
  output logic [bus_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  res_valid,
  input  logic [op_w-1:0]       res_value,
  input  fp_flags_t             res_flags,
  output logic                  op_valid,
  output logic [op_w-1:0]       op_a,
  output logic [op_w-1:0]       op_b,
  output round_mode_t           op_rmode
);

  localparam int hi_w   = op_w - bus_data_w;
  localparam int done_w = status_done_hi - status_done_lo + 1;

  logic [op_w-1:0]   a_q;
  logic [op_w-1:0]   b_q;
  logic [op_w-1:0]   res_q;
  round_mode_t       rmode_q;
  fp_flags_t         flags_q;
  logic [done_w-1:0] done_q;
  logic [1:0]        inflight_q;
  logic              access;
  logic              addr_ok;
  logic              res_read;
  logic              wr_en;
  logic              ctrl_wr;
  logic              busy;
  fp_flags_t         clear_mask;
  fp_flags_t         set_mask;

  assign access = psel && penable;

  always_comb begin
    case (paddr)
      addr_a_lo, addr_a_hi, addr_b_lo, addr_b_hi, addr_ctrl,
      addr_status, addr_res_lo, addr_res_hi, addr_flags: addr_ok = 1'b1;
      default: addr_ok = 1'b0;
    endcase
  end

  assign busy     = (inflight_q != 2'd0);
  assign res_read = !pwrite && (paddr == addr_res_lo || paddr == addr_res_hi);

  // result reads wait for the pipeline to drain
  assign pready  = access && !(res_read && busy);
  assign pslverr = access && !addr_ok;

  assign wr_en    = access && pwrite && addr_ok;
  assign ctrl_wr  = wr_en && (paddr == addr_ctrl);
  assign op_valid = ctrl_wr && pwdata[ctrl_start];
  assign op_rmode = ctrl_wr ? round_mode_t'(pwdata[ctrl_rmode_hi:ctrl_rmode_lo]) : rmode_q;
  assign op_a     = a_q;
  assign op_b     = b_q;

  // new flags win over a write-one-to-clear
  assign clear_mask = (wr_en && paddr == addr_flags) ? pwdata[flag_w-1:0] : '0;
  assign set_mask   = res_valid ? res_flags : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      rmode_q <= rnd_even;
      flags_q <= '0;
      done_q <= '0;
      inflight_q <= '0;
    end else begin
      if (ctrl_wr) begin
        rmode_q <= round_mode_t'(pwdata[ctrl_rmode_hi:ctrl_rmode_lo]);
      end
      flags_q <= (flags_q & ~clear_mask) | set_mask;
      if (res_valid) begin
        done_q <= done_q + 1'b1;
      end
      case ({op_valid, res_valid})
        2'b10: inflight_q <= inflight_q + 2'd1;
        2'b01: inflight_q <= inflight_q - 2'd1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (paddr)
        addr_a_lo: a_q[bus_data_w-1:0] <= pwdata;
        addr_a_hi: a_q[op_w-1:bus_data_w] <= pwdata[hi_w-1:0];
        addr_b_lo: b_q[bus_data_w-1:0] <= pwdata;
        addr_b_hi: b_q[op_w-1:bus_data_w] <= pwdata[hi_w-1:0];
        default: ;
      endcase
    end
    if (res_valid) begin
      res_q <= res_value;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      addr_a_lo:   prdata = a_q[bus_data_w-1:0];
      addr_a_hi:   prdata[hi_w-1:0] = a_q[op_w-1:bus_data_w];
      addr_b_lo:   prdata = b_q[bus_data_w-1:0];
      addr_b_hi:   prdata[hi_w-1:0] = b_q[op_w-1:bus_data_w];
      addr_ctrl:   prdata[ctrl_rmode_hi:ctrl_rmode_lo] = rmode_q;
      addr_status: begin
        prdata[status_busy] = busy;
        prdata[status_done_hi:status_done_lo] = done_q;
      end
      addr_res_lo: prdata = res_q[bus_data_w-1:0];
      addr_res_hi: prdata[hi_w-1:0] = res_q[op_w-1:bus_data_w];
      addr_flags:  prdata[flag_w-1:0] = flags_q;
      default: ;
    endcase
  end

  // a result only returns while an operation is in flight
  assert property (@(posedge clk) disable iff (reset) res_valid |-> busy);

endmodule

/* verilog/fmul_bus_pkg.sv */
package fmul_bus_pkg;

  localparam int bus_data_w = 32;
  localparam int addr_w     = 8;

  // register map, byte addresses
  typedef enum logic [addr_w-1:0] {
    addr_a_lo   = 8'h00,
    addr_a_hi   = 8'h04,
    addr_b_lo   = 8'h08,
    addr_b_hi   = 8'h0C,
    addr_ctrl   = 8'h10,
    addr_status = 8'h14,
    addr_res_lo = 8'h18,
    addr_res_hi = 8'h1C,
    addr_flags  = 8'h20
  } reg_addr_t;

  // control fields
  localparam int ctrl_start    = 8;
  localparam int ctrl_rmode_lo = 0;
  localparam int ctrl_rmode_hi = 1;

  // status fields
  localparam int status_busy    = 0;
  localparam int status_done_lo = 8;
  localparam int status_done_hi = 15;

endpackage

/* verilog/fmul_core.sv */
module fmul_core import fmul_fp_pkg::*; #(
  parameter int exp_w  = 11,
  parameter int frac_w = 52
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  op_valid,
  input  logic [exp_w+frac_w:0] op_a,
  input  logic [exp_w+frac_w:0] op_b,
  input  round_mode_t           op_rmode,
  output logic                  res_valid,
  output logic [exp_w+frac_w:0] res_value,
  output fp_flags_t             res_flags
);

  // decode outputs
  logic                    dec_sign;
  logic signed [exp_w+1:0] dec_exp;
  logic [frac_w:0]         dec_sig_a;
  logic [frac_w:0]         dec_sig_b;
  fp_class_t               dec_class;
  logic                    dec_invalid;

  // stage 1
  logic                    s1_valid;
  logic                    s1_sign;
  logic signed [exp_w+1:0] s1_exp;
  logic [frac_w:0]         s1_sig_a;
  logic [frac_w:0]         s1_sig_b;
  fp_class_t               s1_class;
  logic                    s1_invalid;
  round_mode_t             s1_rmode;

  // stage 2, product register sits in the tree
  logic                    s2_valid;
  logic                    s2_sign;
  logic signed [exp_w+1:0] s2_exp;
  fp_class_t               s2_class;
  logic                    s2_invalid;
  round_mode_t             s2_rmode;
  logic [2*frac_w+1:0]     s2_product;

  logic [exp_w+frac_w:0]   rnd_result;
  fp_flags_t               rnd_flags;

  fmul_exponent #(.exp_w(exp_w), .frac_w(frac_w)) u_exponent (
    .op_a          (op_a),
    .op_b          (op_b),
    .sign          (dec_sign),
    .exp_sum       (dec_exp),
    .sig_a         (dec_sig_a),
    .sig_b         (dec_sig_b),
    .special_class (dec_class),
    .invalid       (dec_invalid)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid;
      s2_valid <= s1_valid;
      res_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign <= dec_sign;
    s1_exp <= dec_exp;
    s1_sig_a <= dec_sig_a;
    s1_sig_b <= dec_sig_b;
    s1_class <= dec_class;
    s1_invalid <= dec_invalid;
    s1_rmode <= op_rmode;
    s2_sign <= s1_sign;
    s2_exp <= s1_exp;
    s2_class <= s1_class;
    s2_invalid <= s1_invalid;
    s2_rmode <= s1_rmode;
    // result holds until the next one arrives
    if (s2_valid) begin
      res_value <= rnd_result;
      res_flags <= rnd_flags;
    end
  end

  fmul_mantissa_tree #(.frac_w(frac_w)) u_tree (
    .clk     (clk),
    .sig_a   (s1_sig_a),
    .sig_b   (s1_sig_b),
    .product (s2_product)
  );

  fmul_round_pack #(.exp_w(exp_w), .frac_w(frac_w)) u_round (
    .product       (s2_product),
    .exp_sum       (s2_exp),
    .sign          (s2_sign),
    .special_class (s2_class),
    .invalid       (s2_invalid),
    .rmode         (s2_rmode),
    .result        (rnd_result),
    .flags         (rnd_flags)
  );

  // fixed three-cycle latency
  assert property (@(posedge clk) disable iff (reset) op_valid |-> ##3 res_valid);

endmodule

/* verilog/fmul_exponent.sv */
module fmul_exponent import fmul_fp_pkg::*; #(
  parameter int exp_w  = 11,
  parameter int frac_w = 52
) (
  input  logic [exp_w+frac_w:0]   op_a,
  input  logic [exp_w+frac_w:0]   op_b,
  output logic                    sign,
  output logic signed [exp_w+1:0] exp_sum,
  output logic [frac_w:0]         sig_a,
  output logic [frac_w:0]         sig_b,
  output fp_class_t               special_class,
  output logic                    invalid
);

  localparam logic signed [exp_w+1:0] bias = (1 << (exp_w - 1)) - 1;

  logic [exp_w-1:0]  ea;
  logic [exp_w-1:0]  eb;
  logic [frac_w-1:0] fa;
  logic [frac_w-1:0] fb;
  logic a_zero;
  logic b_zero;
  logic a_inf;
  logic b_inf;
  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic inf_x_zero;

  assign ea = op_a[exp_w+frac_w-1:frac_w];
  assign eb = op_b[exp_w+frac_w-1:frac_w];
  assign fa = op_a[frac_w-1:0];
  assign fb = op_b[frac_w-1:0];

  // subnormals are taken as zero
  assign a_zero = (ea == '0);
  assign b_zero = (eb == '0);
  assign a_inf  = (&ea) && (fa == '0);
  assign b_inf  = (&eb) && (fb == '0);
  assign a_nan  = (&ea) && (fa != '0);
  assign b_nan  = (&eb) && (fb != '0);
  // quiet bit is the top fraction bit
  assign a_snan = a_nan && !fa[frac_w-1];
  assign b_snan = b_nan && !fb[frac_w-1];
  assign inf_x_zero = (a_inf && b_zero) || (b_inf && a_zero);

  assign sign  = op_a[exp_w+frac_w] ^ op_b[exp_w+frac_w];
  assign sig_a = a_zero ? '0 : {1'b1, fa};
  assign sig_b = b_zero ? '0 : {1'b1, fb};

  // biased sum, one bias removed
  assign exp_sum = $signed({2'b00, ea}) + $signed({2'b00, eb}) - bias;

  always_comb begin
    if (a_nan || b_nan || inf_x_zero) begin
      special_class = cls_nan;
    end else if (a_inf || b_inf) begin
      special_class = cls_infinity;
    end else if (a_zero || b_zero) begin
      special_class = cls_zero;
    end else begin
      special_class = cls_normal;
    end
  end

  assign invalid = inf_x_zero || a_snan || b_snan;

endmodule

/* verilog/fmul_fp_pkg.sv */
package fmul_fp_pkg;

  // rounding direction, encoded as in the control register
  typedef enum logic [1:0] {
    rnd_even  = 2'd0,
    rnd_zero  = 2'd1,
    rnd_plus  = 2'd2,
    rnd_minus = 2'd3
  } round_mode_t;

  // result class after operand decode
  typedef enum logic [1:0] {
    cls_normal   = 2'd0,
    cls_zero     = 2'd1,
    cls_infinity = 2'd2,
    cls_nan      = 2'd3
  } fp_class_t;

  // exception flag word
  localparam int flag_w         = 4;
  localparam int flag_invalid   = 0;
  localparam int flag_overflow  = 1;
  localparam int flag_underflow = 2;
  localparam int flag_inexact   = 3;

  typedef logic [flag_w-1:0] fp_flags_t;

endpackage

/* verilog/fmul_mantissa_tree.sv */
module fmul_mantissa_tree #(
  parameter int frac_w = 52
) (
  input  logic                  clk,
  input  logic [frac_w:0]       sig_a,
  input  logic [frac_w:0]       sig_b,
  output logic [2*frac_w+1:0]   product
);

  localparam int sw = frac_w + 1;
  localparam int pw = 2 * sw;

  logic [pw-1:0] sum_row;
  logic [pw-1:0] carry_row;
  logic [pw-1:0] sum_q;
  logic [pw-1:0] carry_q;

  // 3:2 compressor chain over the partial products
  always_comb begin
    logic [pw-1:0] pp;
    logic [pw-1:0] s;
    logic [pw-1:0] c;
    logic [pw-1:0] c_next;
    s = '0;
    c = '0;
    for (int i = 0; i < sw; i++) begin
      pp = sig_b[i] ? (pw'(sig_a) << i) : '0;
      c_next = ((s & c) | (s & pp) | (c & pp)) << 1;
      s = s ^ c ^ pp;
      c = c_next;
    end
    sum_row = s;
    carry_row = c;
  end

  // carry-save rows registered here, this is stage 2
  always_ff @(posedge clk) begin
    sum_q <= sum_row;
    carry_q <= carry_row;
  end

  // final carry-propagate add
  assign product = sum_q + carry_q;

endmodule

/* verilog/fmul_round_pack.sv */
module fmul_round_pack import fmul_fp_pkg::*; #(
  parameter int exp_w  = 11,
  parameter int frac_w = 52
) (
  input  logic [2*frac_w+1:0]     product,
  input  logic signed [exp_w+1:0] exp_sum,
  input  logic                    sign,
  input  fp_class_t               special_class,
  input  logic                    invalid,
  input  round_mode_t             rmode,
  output logic [exp_w+frac_w:0]   result,
  output fp_flags_t               flags
);

  localparam int pw = 2 * frac_w + 2;
  localparam logic signed [exp_w+1:0] exp_max = (1 << exp_w) - 1;

  logic [pw-1:0]           norm;
  logic [frac_w:0]         sig;
  logic                    round_bit;
  logic                    sticky;
  logic                    lose;
  logic                    round_up;
  logic                    to_max;
  logic [frac_w+1:0]       sig_rnd;
  logic signed [exp_w+1:0] exp_fin;

  // product lies in [1,4), shift by one when below 2
  assign norm      = product[pw-1] ? product : product << 1;
  assign sig       = norm[pw-1:frac_w+1];
  assign round_bit = norm[frac_w];
  assign sticky    = |norm[frac_w-1:0];
  assign lose      = round_bit | sticky;

  always_comb begin
    case (rmode)
      rnd_even:  round_up = round_bit && (sticky || sig[0]);
      rnd_plus:  round_up = lose && !sign;
      rnd_minus: round_up = lose && sign;
      default:   round_up = 1'b0;
    endcase
  end

  assign sig_rnd = {1'b0, sig} + (frac_w + 2)'(round_up);

  // carry out of the significand bumps the exponent
  assign exp_fin = exp_sum + $signed({1'b0, product[pw-1]})
                 + $signed({1'b0, sig_rnd[frac_w+1]});

  // saturate instead of going to infinity
  assign to_max = (rmode == rnd_zero) || (rmode == rnd_plus && sign)
               || (rmode == rnd_minus && !sign);

  always_comb begin
    result = {sign, exp_fin[exp_w-1:0], sig_rnd[frac_w-1:0]};
    flags = '0;
    flags[flag_invalid] = invalid;
    case (special_class)
      cls_nan: result = {1'b0, {exp_w{1'b1}}, 1'b1, {(frac_w - 1){1'b0}}};
      cls_infinity: result = {sign, {exp_w{1'b1}}, {frac_w{1'b0}}};
      cls_zero: result = {sign, {(exp_w + frac_w){1'b0}}};
      default: begin
        flags[flag_inexact] = lose;
        if (exp_fin >= exp_max) begin
          if (to_max) begin
            result = {sign, {(exp_w - 1){1'b1}}, 1'b0, {frac_w{1'b1}}};
          end else begin
            result = {sign, {exp_w{1'b1}}, {frac_w{1'b0}}};
          end
          flags[flag_overflow] = 1'b1;
          flags[flag_inexact] = 1'b1;
        end else if (exp_fin < 1) begin
          // flush to zero
          result = {sign, {(exp_w + frac_w){1'b0}}};
          flags[flag_underflow] = 1'b1;
          flags[flag_inexact] = 1'b1;
        end
      end
    endcase
  end

  // NaN encodings only come from the special path
  always_comb begin
    if ((&result[exp_w+frac_w-1:frac_w]) && (|result[frac_w-1:0])) begin
      assert (!flags[flag_overflow])
        else $error("NaN result with overflow flag set");
    end
  end

endmodule

/* verilog/fmul_unit.sv */
module fmul_unit import fmul_fp_pkg::*; import fmul_bus_pkg::*; #(
  parameter int exp_w  = 11,
  parameter int frac_w = 52
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [addr_w-1:0]     paddr,
  input  logic [bus_data_w-1:0] pwdata,
  output logic [bus_data_w-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  localparam int op_w = exp_w + frac_w + 1;

  logic            op_valid;
  logic [op_w-1:0] op_a;
  logic [op_w-1:0] op_b;
  round_mode_t     op_rmode;
  logic            res_valid;
  logic [op_w-1:0] res_value;
  fp_flags_t       res_flags;

  fmul_apb_regs #(.op_w(op_w)) u_regs (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .res_valid (res_valid),
    .res_value (res_value),
    .res_flags (res_flags),
    .op_valid  (op_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_rmode  (op_rmode)
  );

  fmul_core #(.exp_w(exp_w), .frac_w(frac_w)) u_core (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_rmode  (op_rmode),
    .res_valid (res_valid),
    .res_value (res_value),
    .res_flags (res_flags)
  );

endmodule
